//--- Makefile
# Verilator build and run of the ICE host bus testbench
VERILATOR ?= verilator
TOP       ?= ice_bus_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

# Build, run, and pass only when the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
+incdir+verilog
verilog/ice_proto_pkg.sv
verilog/ice_bus_pkg.sv
verilog/ice_bus_controller.sv
verilog/basics_int.sv
verilog/gpio_int.sv
verilog/ice_bus.sv
testbench/ice_bus_tb.sv

//--- testbench/ice_bus_tb.sv
`timescale 1ns/1ps
`include "ice_settings.svh"

module ice_bus_tb;

	// Run length budget
	localparam int period_ns = 100;
	localparam int reset_cycles = 16;
	localparam int num_tests = 5;
	localparam int cycles_per_test = 2000;
	localparam longint watchdog_ns =
		longint'(reset_cycles + num_tests * cycles_per_test) * period_ns;

	// Clock is the port named reset, reset the port named clk
	logic                     reset;
	logic                     clk;
	ice_proto_pkg::ice_char_t rx_char;
	logic                     rx_valid;
	logic                     rx_ready;
	ice_proto_pkg::ice_char_t tx_char;
	logic                     tx_valid;
	logic                     tx_ready;
	ice_bus_pkg::gpio_vec_t   gpio_in;
	ice_bus_pkg::gpio_vec_t   gpio_out;
	ice_bus_pkg::gpio_vec_t   gpio_oe;
	int                       seed = 36;

	ice_bus dut (
		.reset(reset),
		.clk(clk),
		.rx_char(rx_char),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready),
		.tx_char(tx_char),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.gpio_oe(gpio_oe)
	);

	// 100 ns period
	always #(period_ns / 2) reset = ~reset;

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_char(input string name, input ice_proto_pkg::ice_char_t actual,
		input ice_proto_pkg::ice_char_t expected);
		if (actual !== expected) begin
			stop_with_failure($sformatf("** Error: %s = 0x%02h, expected 0x%02h",
				name, actual, expected));
		end
	endtask

	task automatic check_gpio(input string name, input ice_bus_pkg::gpio_vec_t actual,
		input ice_bus_pkg::gpio_vec_t expected);
		if (actual !== expected) begin
			stop_with_failure($sformatf("** Error: %s = 0x%02h, expected 0x%02h",
				name, actual, expected));
		end
	endtask

	// One byte per accepted handshake, driven on the falling edge
	task automatic send_frame(input ice_proto_pkg::ice_char_t bytes[$]);
		foreach (bytes[i]) begin
			@(negedge reset);
			rx_char = bytes[i];
			rx_valid = 1'b1;
			// rx_ready is a flop output, steady here
			while (!rx_ready) begin
				@(negedge reset);
			end
		end
		@(negedge reset);
		rx_valid = 1'b0;
	endtask

	// Mode 0 always ready, 1 fixed two-of-three, 2 random
	task automatic expect_frame(input string label, input ice_proto_pkg::ice_char_t exp[$],
		input int bp_mode, input bit check_rx);
		int  recv;
		int  cyc;
		bit  rdy;
		recv = 0;
		cyc = 0;
		while (recv < exp.size()) begin
			@(negedge reset);
			case (bp_mode)
				0:       rdy = 1'b1;
				1:       rdy = (cyc % 3) != 2;
				default: rdy = $random(seed) & 1;
			endcase
			tx_ready = rdy;
			// Last slave beat enters the output register with the byte before it
			if (check_rx && recv < exp.size() - 1 && rx_ready) begin
				stop_with_failure($sformatf("rx_ready went high before the %s was sent", label));
			end
			// Transfer happens at the next rising edge
			if (tx_valid && rdy) begin
				check_char($sformatf("tx_char (%s byte %0d)", label, recv), tx_char, exp[recv]);
				recv++;
			end
			cyc++;
		end
		@(negedge reset);
		tx_ready = 1'b0;
		if (check_rx && !rx_ready) begin
			stop_with_failure($sformatf("rx_ready still low after the %s", label));
		end
	endtask

	// Host side stays idle for a number of cycles
	task automatic expect_quiet(input int cycles);
		@(negedge reset);
		tx_ready = 1'b1;
		repeat (cycles) begin
			@(negedge reset);
			if (tx_valid) begin
				stop_with_failure("unexpected frame on the host output");
			end
		end
		tx_ready = 1'b0;
	endtask

	task automatic version_query(input ice_proto_pkg::ice_char_t id, input int bp_mode,
		input bit check_rx);
		ice_proto_pkg::ice_char_t cmd_q[$];
		ice_proto_pkg::ice_char_t rsp_q[$];
		cmd_q = '{ice_proto_pkg::CMD_VERSION, id, 8'd0};
		rsp_q = '{ice_proto_pkg::RESP_ACK, id, 8'd2, `ICE_VERSION_MAJOR, `ICE_VERSION_MINOR};
		send_frame(cmd_q);
		expect_frame("version reply", rsp_q, bp_mode, check_rx);
	endtask

	task automatic set_field(input ice_proto_pkg::ice_char_t sel,
		input ice_proto_pkg::ice_char_t value, input ice_proto_pkg::ice_char_t id);
		ice_proto_pkg::ice_char_t cmd_q[$];
		ice_proto_pkg::ice_char_t rsp_q[$];
		cmd_q = '{ice_proto_pkg::CMD_SET, id, 8'd2, sel, value};
		rsp_q = '{ice_proto_pkg::RESP_ACK, id, 8'd0};
		send_frame(cmd_q);
		expect_frame("set reply", rsp_q, 0, 1'b0);
	endtask

	task automatic get_field(input ice_proto_pkg::ice_char_t sel,
		input ice_proto_pkg::ice_char_t id, input ice_proto_pkg::ice_char_t value,
		input int bp_mode, input bit check_rx);
		ice_proto_pkg::ice_char_t cmd_q[$];
		ice_proto_pkg::ice_char_t rsp_q[$];
		cmd_q = '{ice_proto_pkg::CMD_GET, id, 8'd1, sel};
		rsp_q = '{ice_proto_pkg::RESP_ACK, id, 8'd1, value};
		send_frame(cmd_q);
		expect_frame("get reply", rsp_q, bp_mode, check_rx);
	endtask

	task automatic expect_nak(input ice_proto_pkg::ice_char_t cmd_q[$]);
		ice_proto_pkg::ice_char_t rsp_q[$];
		// Event id is the second byte of every frame
		rsp_q = '{ice_proto_pkg::RESP_NAK, cmd_q[1], 8'd0};
		send_frame(cmd_q);
		expect_frame("nak reply", rsp_q, 1, 1'b0);
	endtask

	task automatic test_version();
		version_query(8'h11, 0, 1'b0);
	endtask

	task automatic test_settings();
		set_field(ice_proto_pkg::SEL_DIRECTION, 8'hf0, 8'h21);
		set_field(ice_proto_pkg::SEL_LEVEL, 8'ha5, 8'h22);
		check_gpio("gpio_oe", gpio_oe, 8'hf0);
		check_gpio("gpio_out", gpio_out, 8'ha5);
		get_field(ice_proto_pkg::SEL_LEVEL, 8'h23, 8'ha5, 1, 1'b0);
	endtask

	task automatic test_nak();
		// Unknown command letter
		expect_nak('{8'h51, 8'h31, 8'd0});
		// Set with a wrong length, payload would clear level
		expect_nak('{ice_proto_pkg::CMD_SET, 8'h32, 8'd3, 8'd0, 8'h00, 8'h00});
		// Selector out of range
		expect_nak('{ice_proto_pkg::CMD_GET, 8'h33, 8'd1, 8'd5});
		check_gpio("gpio_oe", gpio_oe, 8'hf0);
		check_gpio("gpio_out", gpio_out, 8'ha5);
		get_field(ice_proto_pkg::SEL_DIRECTION, 8'h34, 8'hf0, 0, 1'b0);
	endtask

	task automatic test_events();
		ice_proto_pkg::ice_char_t evt_q[$];
		set_field(ice_proto_pkg::SEL_INT_ENABLE, 8'h03, 8'h41);
		@(negedge reset);
		gpio_in[0] = 1'b1;
		// E, tag, length, mask, inputs
		evt_q = '{ice_proto_pkg::CMD_EVENT, 8'h01, 8'd2, 8'h01, 8'h01};
		expect_frame("event frame", evt_q, 0, 1'b0);
		// Pin 4 not enabled
		@(negedge reset);
		gpio_in[4] = 1'b1;
		expect_quiet(50);
		@(negedge reset);
		gpio_in[1] = 1'b1;
		evt_q = '{ice_proto_pkg::CMD_EVENT, 8'h02, 8'd2, 8'h02, 8'h13};
		expect_frame("event frame", evt_q, 1, 1'b0);
	endtask

	task automatic test_backpressure();
		version_query(8'h51, 2, 1'b1);
		get_field(ice_proto_pkg::SEL_LEVEL, 8'h52, 8'ha5, 2, 1'b1);
	endtask

	// Watchdog
	initial begin
		#(watchdog_ns);
		stop_with_failure("timeout, the tests did not finish in their cycle budget");
	end

	initial begin
		reset = 1'b0;
		clk = 1'b1;
		rx_char = '0;
		rx_valid = 1'b0;
		tx_ready = 1'b0;
		gpio_in = '0;
		repeat (reset_cycles) @(negedge reset);
		clk = 1'b0;
		// Idle state after reset
		@(negedge reset);
		if (!rx_ready) begin
			stop_with_failure("rx_ready low after reset");
		end
		if (tx_valid) begin
			stop_with_failure("tx_valid high after reset");
		end
		check_gpio("gpio_oe", gpio_oe, 8'h00);
		test_version();
		test_settings();
		test_nak();
		test_events();
		test_backpressure();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- verilog/basics_int.sv
`timescale 1ns/1ps
`include "ice_settings.svh"

module basics_int (
	input  logic                   reset,
	input  logic                   clk,
	input  ice_bus_pkg::ma_bus_t   ma_bus,
	input  logic                   unknown,
	output logic                   sl_request,
	output logic                   sl_valid,
	output ice_bus_pkg::sl_beat_t  sl_beat,
	input  logic                   sl_grant,
	input  logic                   sl_ready,
	output ice_bus_pkg::gpio_cfg_t gpio_cfg
);

	logic                     fv_q;
	logic                     frame_start;
	logic                     frame_end;
	logic                     pl_idx;
	ice_proto_pkg::cmd_e      cmd_q;
	ice_proto_pkg::ice_char_t evt_id;
	ice_proto_pkg::ice_char_t pl [2];
	ice_proto_pkg::ice_char_t rsp [5];
	ice_proto_pkg::ice_char_t rsp_next [5];
	ice_proto_pkg::ice_char_t field;
	logic [2:0]               last_idx;
	logic [2:0]               last_next;
	logic [2:0]               tx_idx;
	logic                     sel_bad;
	logic                     nak;
	logic                     do_set;

	assign frame_start = ma_bus.frame_valid & ~fv_q;
	assign frame_end = fv_q & ~ma_bus.frame_valid;

	// Selector only matters for set and get
	assign sel_bad = (cmd_q == ice_proto_pkg::CMD_SET || cmd_q == ice_proto_pkg::CMD_GET) &&
		(pl[0] > ice_proto_pkg::SEL_INT_ENABLE);
	assign nak = unknown | sel_bad;
	assign do_set = frame_end & ~nak & (cmd_q == ice_proto_pkg::CMD_SET);

	// Selected setting for a get
	always_comb begin
		case (pl[0])
			ice_proto_pkg::SEL_LEVEL:     field = ice_proto_pkg::ice_char_t'(gpio_cfg.level);
			ice_proto_pkg::SEL_DIRECTION: field = ice_proto_pkg::ice_char_t'(gpio_cfg.direction);
			default:                      field = ice_proto_pkg::ice_char_t'(gpio_cfg.int_enable);
		endcase
	end

	// Response bytes, ACK with no payload unless noted
	always_comb begin
		rsp_next[0] = ice_proto_pkg::RESP_ACK;
		rsp_next[1] = evt_id;
		rsp_next[2] = 8'd0;
		rsp_next[3] = `ICE_VERSION_MAJOR;
		rsp_next[4] = `ICE_VERSION_MINOR;
		last_next = 3'd2;
		if (nak) begin
			rsp_next[0] = ice_proto_pkg::RESP_NAK;
		end else if (cmd_q == ice_proto_pkg::CMD_VERSION) begin
			rsp_next[2] = 8'd2;
			last_next = 3'd4;
		end else if (cmd_q == ice_proto_pkg::CMD_GET) begin
			rsp_next[2] = 8'd1;
			rsp_next[3] = field;
			last_next = 3'd3;
		end
	end

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			fv_q <= 1'b0;
			pl_idx <= 1'b0;
			sl_request <= 1'b0;
			tx_idx <= '0;
			gpio_cfg <= '0;
		end else begin
			fv_q <= ma_bus.frame_valid;
			if (frame_start) begin
				pl_idx <= 1'b0;
			end else if (ma_bus.data_valid) begin
				pl_idx <= ~pl_idx;
			end
			// Second payload byte is the new value
			if (do_set) begin
				case (pl[0])
					ice_proto_pkg::SEL_LEVEL:     gpio_cfg.level <= ice_bus_pkg::gpio_vec_t'(pl[1]);
					ice_proto_pkg::SEL_DIRECTION: gpio_cfg.direction <= ice_bus_pkg::gpio_vec_t'(pl[1]);
					default:                      gpio_cfg.int_enable <= ice_bus_pkg::gpio_vec_t'(pl[1]);
				endcase
			end
			// Request held until the last beat leaves
			if (frame_end) begin
				sl_request <= 1'b1;
				tx_idx <= '0;
			end else if (sl_valid && sl_ready) begin
				if (sl_beat.last) begin
					sl_request <= 1'b0;
				end else begin
					tx_idx <= tx_idx + 3'd1;
				end
			end
		end
	end

	// Frame contents and response buffer
	always_ff @(posedge reset) begin
		if (frame_start) begin
			cmd_q <= ma_bus.cmd;
			evt_id <= ma_bus.data;
		end
		if (ma_bus.data_valid) begin
			pl[pl_idx] <= ma_bus.data;
		end
		if (frame_end) begin
			rsp <= rsp_next;
			last_idx <= last_next;
		end
	end

	assign sl_valid = sl_request & sl_grant;

	always_comb begin
		sl_beat.data = rsp[tx_idx];
		sl_beat.last = (tx_idx == last_idx);
	end

endmodule

//--- verilog/gpio_int.sv
`timescale 1ns/1ps

module gpio_int (
	input  logic                   reset,
	input  logic                   clk,
	input  ice_bus_pkg::gpio_cfg_t gpio_cfg,
	input  ice_bus_pkg::gpio_vec_t gpio_in,
	output ice_bus_pkg::gpio_vec_t gpio_out,
	output ice_bus_pkg::gpio_vec_t gpio_oe,
	output logic                   sl_request,
	output logic                   sl_valid,
	output ice_bus_pkg::sl_beat_t  sl_beat,
	input  logic                   sl_grant,
	input  logic                   sl_ready
);

	ice_bus_pkg::gpio_vec_t   sync1;
	ice_bus_pkg::gpio_vec_t   sync2;
	ice_bus_pkg::gpio_vec_t   sync3;
	ice_bus_pkg::gpio_vec_t   rise;
	ice_bus_pkg::gpio_vec_t   pending;
	ice_bus_pkg::gpio_vec_t   mask_q;
	ice_bus_pkg::gpio_vec_t   in_q;
	ice_proto_pkg::ice_char_t evt_ctr;
	logic [2:0]               tx_idx;
	logic                     snap;

	// Rising edges on interrupt-enabled pins only
	assign rise = sync2 & ~sync3 & gpio_cfg.int_enable;
	// Start a new event frame once the previous one is gone
	assign snap = (pending != '0) & ~sl_request;

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			gpio_out <= '0;
			gpio_oe <= '0;
			sync1 <= '0;
			sync2 <= '0;
			sync3 <= '0;
			pending <= '0;
			evt_ctr <= '0;
			sl_request <= 1'b0;
			tx_idx <= '0;
		end else begin
			gpio_out <= gpio_cfg.level;
			gpio_oe <= gpio_cfg.direction;
			// Two-flop synchronizer, third flop for the edge
			sync1 <= gpio_in;
			sync2 <= sync1;
			sync3 <= sync2;
			if (snap) begin
				// Edges in this cycle go to the next frame
				pending <= rise;
				evt_ctr <= evt_ctr + 8'd1;
				sl_request <= 1'b1;
				tx_idx <= '0;
			end else begin
				pending <= pending | rise;
				if (sl_valid && sl_ready) begin
					if (sl_beat.last) begin
						sl_request <= 1'b0;
					end else begin
						tx_idx <= tx_idx + 3'd1;
					end
				end
			end
		end
	end

	// Event payload captured at snapshot
	always_ff @(posedge reset) begin
		if (snap) begin
			mask_q <= pending;
			in_q <= sync2;
		end
	end

	assign sl_valid = sl_request & sl_grant;

	// Event frame: E, tag, length 2, mask, inputs
	always_comb begin
		sl_beat.last = (tx_idx == 3'd4);
		case (tx_idx)
			3'd0:    sl_beat.data = ice_proto_pkg::CMD_EVENT;
			3'd1:    sl_beat.data = evt_ctr;
			3'd2:    sl_beat.data = 8'd2;
			3'd3:    sl_beat.data = ice_proto_pkg::ice_char_t'(mask_q);
			default: sl_beat.data = ice_proto_pkg::ice_char_t'(in_q);
		endcase
	end

endmodule

//--- verilog/ice_bus.sv
`timescale 1ns/1ps
`include "ice_settings.svh"

module ice_bus (
	input  logic                     reset,
	input  logic                     clk,
	input  ice_proto_pkg::ice_char_t rx_char,
	input  logic                     rx_valid,
	output logic                     rx_ready,
	output ice_proto_pkg::ice_char_t tx_char,
	output logic                     tx_valid,
	input  logic                     tx_ready,
	input  ice_bus_pkg::gpio_vec_t   gpio_in,
	output ice_bus_pkg::gpio_vec_t   gpio_out,
	output ice_bus_pkg::gpio_vec_t   gpio_oe
);

	ice_bus_pkg::ma_bus_t                          ma_bus;
	logic                                          unknown;
	logic [`ICE_NUM_DEV-1:0]                       sl_request;
	logic [`ICE_NUM_DEV-1:0]                       sl_grant;
	logic [`ICE_NUM_DEV-1:0]                       sl_valid;
	ice_bus_pkg::sl_beat_t [`ICE_NUM_DEV-1:0]      sl_beat;
	logic                                          sl_ready;
	ice_bus_pkg::gpio_cfg_t                        gpio_cfg;

	// Host framing, broadcast and response arbitration
	ice_bus_controller #(
		.num_dev(`ICE_NUM_DEV)
	) ctrl0 (
		.reset(reset),
		.clk(clk),
		.rx_char(rx_char),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready),
		.tx_char(tx_char),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.ma_bus(ma_bus),
		.unknown(unknown),
		.sl_request(sl_request),
		.sl_grant(sl_grant),
		.sl_beat(sl_beat),
		.sl_valid(sl_valid),
		.sl_ready(sl_ready)
	);

	// Slave 0, highest priority
	basics_int bi0 (
		.reset(reset),
		.clk(clk),
		.ma_bus(ma_bus),
		.unknown(unknown),
		.sl_request(sl_request[0]),
		.sl_valid(sl_valid[0]),
		.sl_beat(sl_beat[0]),
		.sl_grant(sl_grant[0]),
		.sl_ready(sl_ready),
		.gpio_cfg(gpio_cfg)
	);

	// Slave 1, unsolicited events
	gpio_int gi1 (
		.reset(reset),
		.clk(clk),
		.gpio_cfg(gpio_cfg),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.gpio_oe(gpio_oe),
		.sl_request(sl_request[1]),
		.sl_valid(sl_valid[1]),
		.sl_beat(sl_beat[1]),
		.sl_grant(sl_grant[1]),
		.sl_ready(sl_ready)
	);

endmodule

//--- verilog/ice_bus_controller.sv
`timescale 1ns/1ps
`include "ice_settings.svh"

module ice_bus_controller #(
	parameter int num_dev = `ICE_NUM_DEV
) (
	input  logic                                 reset,
	input  logic                                 clk,
	input  ice_proto_pkg::ice_char_t             rx_char,
	input  logic                                 rx_valid,
	output logic                                 rx_ready,
	output ice_proto_pkg::ice_char_t             tx_char,
	output logic                                 tx_valid,
	input  logic                                 tx_ready,
	output ice_bus_pkg::ma_bus_t                 ma_bus,
	output logic                                 unknown,
	input  logic [num_dev-1:0]                   sl_request,
	output logic [num_dev-1:0]                   sl_grant,
	input  ice_bus_pkg::sl_beat_t [num_dev-1:0]  sl_beat,
	input  logic [num_dev-1:0]                   sl_valid,
	output logic                                 sl_ready
);

	typedef enum logic [2:0] {
		ST_CMD,
		ST_ID,
		ST_LEN,
		ST_DATA,
		ST_WAIT
	} state_t;

	state_t                   state;
	ice_proto_pkg::cmd_e      cmd_q;
	ice_proto_pkg::ice_char_t id_q;
	ice_proto_pkg::ice_char_t len_cnt;
	logic                     bad_q;
	logic                     ma_last;
	logic                     rx_xfer;
	logic                     len_bad;
	logic [num_dev-1:0]       grant_next;
	ice_bus_pkg::sl_beat_t    beat_sel;
	logic                     valid_sel;
	logic                     sl_xfer;
	logic                     resp_done;

	// Host input stalls while a response is outstanding
	assign rx_ready = (state != ST_WAIT);
	assign rx_xfer = rx_valid & rx_ready;

	// Length byte checked against the command
	always_comb begin
		case (cmd_q)
			ice_proto_pkg::CMD_VERSION: len_bad = (rx_char != 8'd0);
			ice_proto_pkg::CMD_SET:     len_bad = (rx_char != 8'd2);
			ice_proto_pkg::CMD_GET:     len_bad = (rx_char != 8'd1);
			default:                    len_bad = 1'b1;
		endcase
		if (rx_char > `ICE_MAX_PAYLOAD) begin
			len_bad = 1'b1;
		end
	end

	// Frame parser and master-bus driver
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			state <= ST_CMD;
			len_cnt <= '0;
			bad_q <= 1'b0;
			ma_last <= 1'b0;
			ma_bus <= '0;
			unknown <= 1'b0;
		end else begin
			ma_bus.data_valid <= 1'b0;
			unknown <= 1'b0;
			// Close the frame one cycle after its last beat
			if (ma_last) begin
				ma_bus.frame_valid <= 1'b0;
				unknown <= bad_q;
				ma_last <= 1'b0;
			end
			case (state)
				ST_CMD: begin
					if (rx_xfer) begin
						state <= ST_ID;
					end
				end
				ST_ID: begin
					if (rx_xfer) begin
						state <= ST_LEN;
					end
				end
				ST_LEN: begin
					if (rx_xfer) begin
						// Header beat, event id on data
						ma_bus.frame_valid <= 1'b1;
						ma_bus.cmd <= cmd_q;
						ma_bus.data <= id_q;
						len_cnt <= rx_char;
						bad_q <= len_bad;
						ma_last <= (rx_char == 8'd0);
						state <= (rx_char == 8'd0) ? ST_WAIT : ST_DATA;
					end
				end
				ST_DATA: begin
					if (rx_xfer) begin
						ma_bus.data <= rx_char;
						ma_bus.data_valid <= 1'b1;
						len_cnt <= len_cnt - 8'd1;
						if (len_cnt == 8'd1) begin
							ma_last <= 1'b1;
							state <= ST_WAIT;
						end
					end
				end
				default: begin
					// Wait for the last basics beat
					if (resp_done) begin
						state <= ST_CMD;
					end
				end
			endcase
		end
	end

	// Header bytes held until the length arrives
	always_ff @(posedge reset) begin
		if (rx_xfer && state == ST_CMD) begin
			cmd_q <= ice_proto_pkg::cmd_e'(rx_char);
		end
		if (rx_xfer && state == ST_ID) begin
			id_q <= rx_char;
		end
	end

	// Fixed priority, lowest index wins
	always_comb begin
		grant_next = '0;
		for (int i = num_dev - 1; i >= 0; i--) begin
			if (sl_request[i]) begin
				grant_next = '0;
				grant_next[i] = 1'b1;
			end
		end
	end

	// Beat mux by grant
	always_comb begin
		beat_sel = '0;
		valid_sel = 1'b0;
		for (int i = 0; i < num_dev; i++) begin
			if (sl_grant[i]) begin
				beat_sel = sl_beat[i];
				valid_sel = sl_valid[i];
			end
		end
	end

	// Output register free or draining this cycle
	assign sl_ready = ~tx_valid | tx_ready;
	assign sl_xfer = valid_sel & sl_ready;
	assign resp_done = sl_xfer & sl_grant[0] & beat_sel.last;

	// Grant held for a whole slave frame
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			sl_grant <= '0;
			tx_valid <= 1'b0;
		end else begin
			if (sl_grant == '0) begin
				sl_grant <= grant_next;
			end else if (sl_xfer && beat_sel.last) begin
				sl_grant <= '0;
			end
			if (sl_xfer) begin
				tx_valid <= 1'b1;
			end else if (tx_ready) begin
				tx_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge reset) begin
		if (sl_xfer) begin
			tx_char <= beat_sel.data;
		end
	end

endmodule

//--- verilog/ice_bus_pkg.sv
`include "ice_settings.svh"

package ice_bus_pkg;

	// One bit per GPIO pin
	typedef logic [`ICE_GPIO_WIDTH-1:0] gpio_vec_t;

	// GPIO settings held by basics
	typedef struct packed {
		gpio_vec_t level;
		gpio_vec_t direction;
		gpio_vec_t int_enable;
	} gpio_cfg_t;

	// Master broadcast bus
	// Header cycle carries the event id on data with data_valid low
	typedef struct packed {
		logic                     frame_valid;
		logic                     data_valid;
		ice_proto_pkg::cmd_e      cmd;
		ice_proto_pkg::ice_char_t data;
	} ma_bus_t;

	// One response byte from a slave
	typedef struct packed {
		ice_proto_pkg::ice_char_t data;
		logic                     last;
	} sl_beat_t;

endpackage

//--- verilog/ice_proto_pkg.sv
`include "ice_settings.svh"

package ice_proto_pkg;

	// One character on the host stream
	typedef logic [7:0] ice_char_t;

	// Command codes, ASCII letters on the wire
	typedef enum logic [7:0] {
		CMD_VERSION = 8'h56,
		CMD_SET     = 8'h53,
		CMD_GET     = 8'h47,
		CMD_EVENT   = 8'h45
	} cmd_e;

	// First byte of every response
	typedef enum logic [7:0] {
		RESP_ACK = 8'h41,
		RESP_NAK = 8'h4e
	} resp_e;

	// GPIO setting selector, first payload byte of set/get
	typedef enum logic [7:0] {
		SEL_LEVEL      = 8'd0,
		SEL_DIRECTION  = 8'd1,
		SEL_INT_ENABLE = 8'd2
	} sel_e;

endpackage

//--- verilog/ice_settings.svh
`ifndef ICE_SETTINGS_SVH
`define ICE_SETTINGS_SVH

// Slave-bus requesters
// Index 0 is basics, index 1 is GPIO
`define ICE_NUM_DEV 2

// GPIO pins on the board header
`define ICE_GPIO_WIDTH 8

// Version query reply bytes
`define ICE_VERSION_MAJOR 8'h02
`define ICE_VERSION_MINOR 8'h05

// Largest accepted length byte
// Longer frames are consumed but answered with a NAK
`define ICE_MAX_PAYLOAD 4

`endif
